/* list.f */
+incdir+include
rtl/lms_pkg.sv
rtl/rx_iq_deinterleave.sv
rtl/tx_iq_interleave.sv
rtl/lms_spi_fanout.sv
rtl/lms_frontend_top.sv
tb/tb_lms_frontend.sv

/* rtl/lms_frontend_top.sv */
// Top level of the LMS front end: two receive and two transmit channels plus the SPI fan-out
`timescale 1ns/100ps

module lms_frontend_top
(
   input  logic                  lms_clk,
   input  logic                  reset_i,

   // Receive channel 1
   input  lms_pkg::lms_sample_t  rx1_data_i,
   input  logic                  rx1_iqsel_i,
   output lms_pkg::core_sample_t rx1_i_o,
   output lms_pkg::core_sample_t rx1_q_o,
   output logic                  rx1_valid_o,
   // Receive channel 2
   input  lms_pkg::lms_sample_t  rx2_data_i,
   input  logic                  rx2_iqsel_i,
   output lms_pkg::core_sample_t rx2_i_o,
   output lms_pkg::core_sample_t rx2_q_o,
   output logic                  rx2_valid_o,

   // Transmit channel 1
   input  lms_pkg::lms_sample_t  tx1_i_i,
   input  lms_pkg::lms_sample_t  tx1_q_i,
   output logic                  tx1_take_o,
   output lms_pkg::lms_sample_t  tx1_data_o,
   output logic                  tx1_iqsel_o,
   // Transmit channel 2
   input  lms_pkg::lms_sample_t  tx2_i_i,
   input  lms_pkg::lms_sample_t  tx2_q_i,
   output logic                  tx2_take_o,
   output lms_pkg::lms_sample_t  tx2_data_o,
   output logic                  tx2_iqsel_o,

   // SPI master side and slave returns
   input  logic                  spi_sclk_i,
   input  logic                  spi_mosi_i,
   input  logic                  sen_dac_i,
   input  logic                  sen_lms1_i,
   input  logic                  sen_lms2_i,
   input  logic                  miso_dac_i,
   input  logic                  miso_lms1_i,
   input  logic                  miso_lms2_i,
   // SPI slave side
   output logic                  sclk_dac_o,
   output logic                  sclk_lms1_o,
   output logic                  mosi_lms1_o,
   output logic                  sclk_lms2_o,
   output logic                  mosi_lms2_o,
   output logic                  spi_miso_o
);

   rx_iq_deinterleave rx1_u
   (
      .lms_clk    (lms_clk),
      .reset_i    (reset_i),
      .rx_data_i  (rx1_data_i),
      .rx_iqsel_i (rx1_iqsel_i),
      .rx_i_o     (rx1_i_o),
      .rx_q_o     (rx1_q_o),
      .rx_valid_o (rx1_valid_o)
   );

   rx_iq_deinterleave rx2_u
   (
      .lms_clk    (lms_clk),
      .reset_i    (reset_i),
      .rx_data_i  (rx2_data_i),
      .rx_iqsel_i (rx2_iqsel_i),
      .rx_i_o     (rx2_i_o),
      .rx_q_o     (rx2_q_o),
      .rx_valid_o (rx2_valid_o)
   );

   // Both interleavers share reset so their phases stay aligned
   tx_iq_interleave tx1_u
   (
      .lms_clk    (lms_clk),
      .reset_i    (reset_i),
      .tx_i_i     (tx1_i_i),
      .tx_q_i     (tx1_q_i),
      .tx_take_o  (tx1_take_o),
      .tx_data_o  (tx1_data_o),
      .tx_iqsel_o (tx1_iqsel_o)
   );

   tx_iq_interleave tx2_u
   (
      .lms_clk    (lms_clk),
      .reset_i    (reset_i),
      .tx_i_i     (tx2_i_i),
      .tx_q_i     (tx2_q_i),
      .tx_take_o  (tx2_take_o),
      .tx_data_o  (tx2_data_o),
      .tx_iqsel_o (tx2_iqsel_o)
   );

   lms_spi_fanout spi_u
   (
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .sen_dac_i   (sen_dac_i),
      .sen_lms1_i  (sen_lms1_i),
      .sen_lms2_i  (sen_lms2_i),
      .miso_dac_i  (miso_dac_i),
      .miso_lms1_i (miso_lms1_i),
      .miso_lms2_i (miso_lms2_i),
      .sclk_dac_o  (sclk_dac_o),
      .sclk_lms1_o (sclk_lms1_o),
      .mosi_lms1_o (mosi_lms1_o),
      .sclk_lms2_o (sclk_lms2_o),
      .mosi_lms2_o (mosi_lms2_o),
      .spi_miso_o  (spi_miso_o)
   );

endmodule

/* rtl/lms_pkg.sv */
// Shared sample widths, sample types and I/Q phase encoding for the LMS front end blocks
package lms_pkg;

   // Word width on the LMS ADC/DAC pins
   localparam int LMS_SAMPLE_W = 12;

   // Core-side receive sample width
   localparam int CORE_SAMPLE_W = 14;

   // Zero LSBs appended when a pin word is left-justified to core width
   localparam int LMS_PAD_W = CORE_SAMPLE_W - LMS_SAMPLE_W;

   typedef logic [LMS_SAMPLE_W-1:0]  lms_sample_t;   // Pin word, TX sample
   typedef logic [CORE_SAMPLE_W-1:0] core_sample_t;  // Rebuilt RX sample

   // TX interleaver state and RX pairing flag
   // RX side reads PHASE_Q as "I stored, waiting for Q"
   typedef enum logic
   {
      PHASE_I = 1'b0,
      PHASE_Q = 1'b1
   } iq_phase_t;

   // Left-justify a pin word into a core sample
   function automatic core_sample_t to_core(input lms_sample_t word);
      return {word, {LMS_PAD_W{1'b0}}};
   endfunction

endpackage

/* rtl/lms_spi_fanout.sv */
// SPI fan-out: routes one master's clock and data to the two LMS chips and the clock DAC
`timescale 1ns/100ps

module lms_spi_fanout
(
   // Master side
   input  logic spi_sclk_i,
   input  logic spi_mosi_i,
   input  logic sen_dac_i,    // Active-low enables
   input  logic sen_lms1_i,
   input  logic sen_lms2_i,
   // Slave returns
   input  logic miso_dac_i,
   input  logic miso_lms1_i,
   input  logic miso_lms2_i,
   // Slave side
   output logic sclk_dac_o,
   output logic sclk_lms1_o,
   output logic mosi_lms1_o,
   output logic sclk_lms2_o,
   output logic mosi_lms2_o,
   output logic spi_miso_o
);

   // DAC sees the raw clock, its enable alone frames the transfer
   assign sclk_dac_o = spi_sclk_i;

   // LMS lines held low while the chip is deselected
   assign sclk_lms1_o = ~sen_lms1_i & spi_sclk_i;
   assign mosi_lms1_o = ~sen_lms1_i & spi_mosi_i;
   assign sclk_lms2_o = ~sen_lms2_i & spi_sclk_i;
   assign mosi_lms2_o = ~sen_lms2_i & spi_mosi_i;

   // Only a selected slave may pull the return line high
   assign spi_miso_o = (~sen_dac_i  & miso_dac_i)
                     | (~sen_lms1_i & miso_lms1_i)
                     | (~sen_lms2_i & miso_lms2_i);

endmodule

/* rtl/rx_iq_deinterleave.sv */
// Receive channel: pairs interleaved I/Q words from an LMS ADC port into aligned core samples
`timescale 1ns/100ps

module rx_iq_deinterleave
(
   input  logic                  lms_clk,
   input  logic                  reset_i,
   input  lms_pkg::lms_sample_t  rx_data_i,
   input  logic                  rx_iqsel_i,   // High = I word, low = Q word
   output lms_pkg::core_sample_t rx_i_o,
   output lms_pkg::core_sample_t rx_q_o,
   output logic                  rx_valid_o
);

   import lms_pkg::*;

   lms_sample_t i_hold;     // Last I word seen
   iq_phase_t   pair_flag;  // PHASE_Q once an I is waiting for its Q

   // I word capture, later I words overwrite earlier ones
   always_ff @(posedge lms_clk)
   begin
      if (rx_iqsel_i)
      begin
         i_hold <= rx_data_i;
      end
   end

   // Pairing flag and output pair
   always_ff @(posedge lms_clk)
   begin
      if (reset_i)
      begin
         pair_flag  <= PHASE_I;
         rx_i_o     <= '0;
         rx_q_o     <= '0;
         rx_valid_o <= 1'b0;
      end
      else
      begin
         rx_valid_o <= 1'b0;  // Strobe lasts one cycle
         if (rx_iqsel_i)
         begin
            pair_flag <= PHASE_Q;
         end
         else if (pair_flag == PHASE_Q)
         begin
            // Q completes the pair, both halves update together
            rx_i_o     <= to_core(i_hold);
            rx_q_o     <= to_core(rx_data_i);
            rx_valid_o <= 1'b1;
            pair_flag  <= PHASE_I;
         end
         // A lone Q with the flag clear is dropped
      end
   end

endmodule

/* rtl/tx_iq_interleave.sv */
// Transmit channel that sends each core I/Q pair as two alternating words on an LMS DAC port
`timescale 1ns/100ps

module tx_iq_interleave
(
   input  logic                 lms_clk,
   input  logic                 reset_i,
   input  lms_pkg::lms_sample_t tx_i_i,
   input  lms_pkg::lms_sample_t tx_q_i,
   output logic                 tx_take_o,   // Pair sampled at the last edge
   output lms_pkg::lms_sample_t tx_data_o,
   output logic                 tx_iqsel_o   // Low = I on the pins, high = Q
);

   import lms_pkg::*;

   iq_phase_t   phase;
   lms_sample_t q_hold;  // Q half waits one cycle behind I

   // Q is captured together with I on the I phase
   always_ff @(posedge lms_clk)
   begin
      if (phase == PHASE_I)
      begin
         q_hold <= tx_q_i;
      end
   end

   // Phase machine and pin drivers
   always_ff @(posedge lms_clk)
   begin
      if (reset_i)
      begin
         phase      <= PHASE_I;
         tx_data_o  <= '0;
         tx_iqsel_o <= 1'b0;
         tx_take_o  <= 1'b0;
      end
      else
      begin
         case (phase)
            PHASE_I:
            begin
               tx_data_o  <= tx_i_i;
               tx_iqsel_o <= 1'b0;
               tx_take_o  <= 1'b1;  // Source may move to its next pair
               phase      <= PHASE_Q;
            end
            PHASE_Q:
            begin
               tx_data_o  <= q_hold;
               tx_iqsel_o <= 1'b1;
               tx_take_o  <= 1'b0;
               phase      <= PHASE_I;
            end
         endcase
      end
   end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compiles the LMS front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_lms_frontend \
   --Mdir obj_dir \
   -f list.f

output="$(./obj_dir/Vtb_lms_frontend)"
echo "$output"

if grep -qx "Finished with no errors" <<< "$output"; then
   exit 0
else
   exit 1
fi

/* include/tb_lms_ref.svh */
// Reference model functions for the front end testbench, included inside the testbench module
`ifndef TB_LMS_REF_SVH
`define TB_LMS_REF_SVH

// Pin word followed by two zero bits
function automatic lms_pkg::core_sample_t exp_rx_word(input lms_pkg::lms_sample_t word);
   return {word, 2'b00};
endfunction

// One receive edge of the pairing rule
// armed and held carry the model state from edge to edge
function automatic void rx_model_step
(
   input  logic                  iqsel,
   input  lms_pkg::lms_sample_t  data,
   inout  logic                  armed,
   inout  lms_pkg::lms_sample_t  held,
   output logic                  valid,
   output lms_pkg::core_sample_t pair_i,
   output lms_pkg::core_sample_t pair_q
);
   valid  = 1'b0;
   pair_i = '0;
   pair_q = '0;
   if (iqsel)
   begin
      held  = data;  // Last I wins
      armed = 1'b1;
   end
   else if (armed)
   begin
      valid  = 1'b1;
      pair_i = exp_rx_word(held);
      pair_q = exp_rx_word(data);
      armed  = 1'b0;
   end
endfunction

// Pin word for the given select level
function automatic lms_pkg::lms_sample_t exp_tx_word
(
   input logic                 iqsel,
   input lms_pkg::lms_sample_t pair_i,
   input lms_pkg::lms_sample_t pair_q
);
   return iqsel ? pair_q : pair_i;
endfunction

// A gated slave line follows the master only while its enable is low
function automatic logic exp_spi_gate(input logic sen_n, input logic line);
   return (sen_n == 1'b0) ? line : 1'b0;
endfunction

// Merged return line
function automatic logic exp_spi_miso
(
   input logic sen_dac,
   input logic sen_lms1,
   input logic sen_lms2,
   input logic miso_dac,
   input logic miso_lms1,
   input logic miso_lms2
);
   return exp_spi_gate(sen_dac, miso_dac)
        | exp_spi_gate(sen_lms1, miso_lms1)
        | exp_spi_gate(sen_lms2, miso_lms2);
endfunction

`endif

/* tb/tb_lms_frontend.sv */
// Testbench for the LMS front end top level, run through list.f with the Verilator script
`timescale 1ns/100ps

module tb_lms_frontend;

   import lms_pkg::*;

   localparam int          RESET_CYCLES = 4;
   localparam int          RX_PAIRS     = 100;
   localparam int          RX_IRREG_LEN = 100;
   localparam int          TX_PAIRS     = 100;
   localparam int          SPI_LEN      = 100;
   // Reset, RX pairs and drain, irregular RX, two cycles per TX pair, SPI
   localparam int          TEST_CYCLES  = RESET_CYCLES + 1 + 2 * RX_PAIRS + 3 + RX_IRREG_LEN + 2
                                          + 2 * TX_PAIRS + 2 + SPI_LEN + 1;
   localparam int          TIMEOUT_CYCLES = 2 * TEST_CYCLES;
   localparam logic [31:0] SEED = 32'h9835_dc8d;

   logic         lms_clk;
   logic         reset_i;
   lms_sample_t  rx1_data_i, rx2_data_i;
   logic         rx1_iqsel_i, rx2_iqsel_i;
   core_sample_t rx1_i_o, rx1_q_o, rx2_i_o, rx2_q_o;
   logic         rx1_valid_o, rx2_valid_o;
   lms_sample_t  tx1_i_i, tx1_q_i, tx2_i_i, tx2_q_i;
   logic         tx1_take_o, tx2_take_o;
   lms_sample_t  tx1_data_o, tx2_data_o;
   logic         tx1_iqsel_o, tx2_iqsel_o;
   logic         spi_sclk_i, spi_mosi_i, sen_dac_i, sen_lms1_i, sen_lms2_i;
   logic         miso_dac_i, miso_lms1_i, miso_lms2_i;
   logic         sclk_dac_o, sclk_lms1_o, mosi_lms1_o, sclk_lms2_o, mosi_lms2_o, spi_miso_o;

   // Model state, index 0 is channel 1
   logic         rx_armed [2];
   lms_sample_t  rx_held [2];
   logic         exp_rx_valid [2];
   core_sample_t exp_rx_i [2];
   core_sample_t exp_rx_q [2];
   iq_phase_t    tx_phase;
   lms_sample_t  tx_pair_i [2];
   lms_sample_t  tx_pair_q [2];
   logic         exp_tx_take;
   logic         exp_tx_iqsel;
   lms_sample_t  exp_tx_data [2];
   logic         model_live = 1'b0;  // Set once reset has reached the DUT

   int err_count   = 0;  // Written by the compare process only
   int check_count = 0;
   int stim_errs   = 0;  // Failures found by the stimulus side
   int test_count  = 0;
   int cycle_count = 0;
   int rx1_seen    = 0;
   int rx2_seen    = 0;

   `include "tb_lms_ref.svh"

   lms_frontend_top dut_i (.*);

   initial
   begin
      lms_clk = 1'b0;
      forever #4 lms_clk = ~lms_clk;
   end

   function automatic int total_errors();
      return err_count + stim_errs;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      err_count++;
      $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected)
      begin
         report_mismatch(name, expected, actual);
      end
   endtask

   task automatic check_rx_channel(input bit ch, input string tag, input logic valid,
                                   input core_sample_t pair_i, input core_sample_t pair_q);
      check_value({tag, "_valid_o"}, 32'(exp_rx_valid[ch]), 32'(valid));
      check_value({tag, "_i_o"}, 32'(exp_rx_i[ch]), 32'(pair_i));
      check_value({tag, "_q_o"}, 32'(exp_rx_q[ch]), 32'(pair_q));
   endtask

   task automatic check_tx_channel(input bit ch, input string tag, input logic take,
                                   input logic iqsel, input lms_sample_t data);
      check_value({tag, "_take_o"}, 32'(exp_tx_take), 32'(take));
      check_value({tag, "_iqsel_o"}, 32'(exp_tx_iqsel), 32'(iqsel));
      check_value({tag, "_data_o"}, 32'(exp_tx_data[ch]), 32'(data));
   endtask

   // Combinational path, inputs have been stable since the falling edge
   task automatic check_spi();
      check_value("sclk_dac_o", 32'(spi_sclk_i), 32'(sclk_dac_o));
      check_value("sclk_lms1_o", 32'(exp_spi_gate(sen_lms1_i, spi_sclk_i)), 32'(sclk_lms1_o));
      check_value("mosi_lms1_o", 32'(exp_spi_gate(sen_lms1_i, spi_mosi_i)), 32'(mosi_lms1_o));
      check_value("sclk_lms2_o", 32'(exp_spi_gate(sen_lms2_i, spi_sclk_i)), 32'(sclk_lms2_o));
      check_value("mosi_lms2_o", 32'(exp_spi_gate(sen_lms2_i, spi_mosi_i)), 32'(mosi_lms2_o));
      check_value("spi_miso_o",
                  32'(exp_spi_miso(sen_dac_i, sen_lms1_i, sen_lms2_i,
                                   miso_dac_i, miso_lms1_i, miso_lms2_i)),
                  32'(spi_miso_o));
   endtask

   task automatic step_rx_model(input bit ch, input logic iqsel, input lms_sample_t data);
      logic         armed;
      lms_sample_t  held;
      logic         valid;
      core_sample_t pair_i;
      core_sample_t pair_q;
      armed = rx_armed[ch];
      held  = rx_held[ch];
      rx_model_step(iqsel, data, armed, held, valid, pair_i, pair_q);
      rx_armed[ch]     = armed;
      rx_held[ch]      = held;
      exp_rx_valid[ch] = valid;
      if (valid)  // Outputs hold between pairs
      begin
         exp_rx_i[ch] = pair_i;
         exp_rx_q[ch] = pair_q;
      end
   endtask

   task automatic step_tx_model();
      if (tx_phase == PHASE_I)
      begin
         tx_pair_i[0] = tx1_i_i;
         tx_pair_q[0] = tx1_q_i;
         tx_pair_i[1] = tx2_i_i;
         tx_pair_q[1] = tx2_q_i;
         exp_tx_take  = 1'b1;
         exp_tx_iqsel = 1'b0;
         tx_phase     = PHASE_Q;
      end
      else
      begin
         exp_tx_take  = 1'b0;
         exp_tx_iqsel = 1'b1;
         tx_phase     = PHASE_I;
      end
      exp_tx_data[0] = exp_tx_word(exp_tx_iqsel, tx_pair_i[0], tx_pair_q[0]);
      exp_tx_data[1] = exp_tx_word(exp_tx_iqsel, tx_pair_i[1], tx_pair_q[1]);
   endtask

   // Compare process: outputs read here still hold the previous edge's result
   always @(posedge lms_clk)
   begin
      if (model_live)
      begin
         check_rx_channel(1'b0, "rx1", rx1_valid_o, rx1_i_o, rx1_q_o);
         check_rx_channel(1'b1, "rx2", rx2_valid_o, rx2_i_o, rx2_q_o);
         check_tx_channel(1'b0, "tx1", tx1_take_o, tx1_iqsel_o, tx1_data_o);
         check_tx_channel(1'b1, "tx2", tx2_take_o, tx2_iqsel_o, tx2_data_o);
         if (rx1_valid_o === 1'b1) rx1_seen++;
         if (rx2_valid_o === 1'b1) rx2_seen++;
      end
      check_spi();
      if (reset_i)
      begin
         for (int c = 0; c < 2; c++)
         begin
            rx_armed[c]     = 1'b0;
            exp_rx_valid[c] = 1'b0;
            exp_rx_i[c]     = '0;
            exp_rx_q[c]     = '0;
            exp_tx_data[c]  = '0;
         end
         tx_phase     = PHASE_I;
         exp_tx_take  = 1'b0;
         exp_tx_iqsel = 1'b0;
         model_live   = 1'b1;
      end
      else
      begin
         step_rx_model(1'b0, rx1_iqsel_i, rx1_data_i);
         step_rx_model(1'b1, rx2_iqsel_i, rx2_data_i);
         step_tx_model();
      end
   end

   task automatic finish_test(input string name, input int errs_before);
      test_count++;
      $display("Test %s done with %0d errors", name, total_errors() - errs_before);
   endtask

   task automatic run_reset_test();
      int errs_before;
      errs_before = total_errors();
      reset_i = 1'b1;
      repeat (RESET_CYCLES) @(negedge lms_clk);
      reset_i = 1'b0;
      @(negedge lms_clk);  // One edge to see the held reset values
      finish_test("reset", errs_before);
   endtask

   task automatic run_rx_pairing_test();
      int errs_before;
      int seen1;
      int seen2;
      errs_before = total_errors();
      seen1 = rx1_seen;
      seen2 = rx2_seen;
      for (int n = 0; n < RX_PAIRS; n++)
      begin
         @(negedge lms_clk);
         rx1_iqsel_i = 1'b1;
         rx1_data_i  = lms_sample_t'($urandom());
         rx2_iqsel_i = 1'b1;
         rx2_data_i  = lms_sample_t'($urandom());
         @(negedge lms_clk);
         rx1_iqsel_i = 1'b0;  // Q completes the pair
         rx1_data_i  = lms_sample_t'($urandom());
         rx2_iqsel_i = 1'b0;
         rx2_data_i  = lms_sample_t'($urandom());
      end
      repeat (3) @(negedge lms_clk);  // Last strobe reaches the compare process
      if (rx1_seen - seen1 != RX_PAIRS || rx2_seen - seen2 != RX_PAIRS)
      begin
         stim_errs++;
         $display("ERROR: receive gave %0d and %0d valid pairs where %0d were sent",
                  rx1_seen - seen1, rx2_seen - seen2, RX_PAIRS);
      end
      finish_test("rx_pairing", errs_before);
   endtask

   // Random select levels give repeated I words and lone Q words
   task automatic run_rx_irregular_test();
      int errs_before;
      errs_before = total_errors();
      repeat (RX_IRREG_LEN)
      begin
         @(negedge lms_clk);
         rx1_iqsel_i = 1'($urandom());
         rx1_data_i  = lms_sample_t'($urandom());
         rx2_iqsel_i = 1'($urandom());
         rx2_data_i  = lms_sample_t'($urandom());
      end
      @(negedge lms_clk);
      rx1_iqsel_i = 1'b0;
      rx2_iqsel_i = 1'b0;
      @(negedge lms_clk);
      finish_test("rx_irregular", errs_before);
   endtask

   task automatic run_tx_interleave_test();
      int errs_before;
      int pairs;
      errs_before = total_errors();
      pairs = 0;
      while (pairs < TX_PAIRS)
      begin
         @(negedge lms_clk);
         if (tx1_take_o === 1'b1)  // Pair just taken, present the next one
         begin
            tx1_i_i = lms_sample_t'($urandom());
            tx1_q_i = lms_sample_t'($urandom());
            tx2_i_i = lms_sample_t'($urandom());
            tx2_q_i = lms_sample_t'($urandom());
            pairs++;
         end
      end
      repeat (2) @(negedge lms_clk);
      finish_test("tx_interleave", errs_before);
   endtask

   task automatic run_spi_test();
      int         errs_before;
      logic [7:0] bits;
      errs_before = total_errors();
      repeat (SPI_LEN)
      begin
         @(negedge lms_clk);
         bits        = 8'($urandom());
         spi_sclk_i  = bits[0];
         spi_mosi_i  = bits[1];
         sen_dac_i   = bits[2];
         sen_lms1_i  = bits[3];
         sen_lms2_i  = bits[4];
         miso_dac_i  = bits[5];
         miso_lms1_i = bits[6];
         miso_lms2_i = bits[7];
      end
      @(negedge lms_clk);
      finish_test("spi_fanout", errs_before);
   endtask

   initial
   begin
      void'($urandom(SEED));
      reset_i     = 1'b1;
      rx1_data_i  = '0;
      rx1_iqsel_i = 1'b0;
      rx2_data_i  = '0;
      rx2_iqsel_i = 1'b0;
      tx1_i_i     = '0;
      tx1_q_i     = '0;
      tx2_i_i     = '0;
      tx2_q_i     = '0;
      spi_sclk_i  = 1'b0;
      spi_mosi_i  = 1'b0;
      sen_dac_i   = 1'b1;  // All slaves deselected
      sen_lms1_i  = 1'b1;
      sen_lms2_i  = 1'b1;
      miso_dac_i  = 1'b0;
      miso_lms1_i = 1'b0;
      miso_lms2_i = 1'b0;
      run_reset_test();
      run_rx_pairing_test();
      run_rx_irregular_test();
      run_tx_interleave_test();
      run_spi_test();
      $display("Totals: %0d tests, %0d checks, %0d errors", test_count, check_count,
               total_errors());
      if (total_errors() == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   initial
   begin
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge lms_clk);
         cycle_count++;
      end
      $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
   end

endmodule
